//--- verilog/uart_config.svh
// ==========================================================================
// Build-time settings of the UART. Baud rate is fixed here, frame is 8N1.
// UART_TICK_DIV must come out as a whole number of at least 1
// ==========================================================================
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// System clock in Hz
`define UART_CLK_FREQ 1000000

// Serial line rate in bits per second
`define UART_BAUD 62500

// Processor bus
`define UART_ADDR_W 16
`define UART_BASE_ADDR 16'hFF10

// Ticks per bit on the line
`define UART_OVERSAMPLE 4

// Clock cycles between two oversample ticks
`define UART_TICK_DIV (`UART_CLK_FREQ / (`UART_OVERSAMPLE * `UART_BAUD))

`endif

//--- verilog/uart_reg_pkg.sv
// ==========================================================================
// Register map of the UART, four byte registers from the base address.
// STATUS error bits are write-1-to-clear, the other bits read only
// ==========================================================================
package uart_reg_pkg;

    // Offset of each register from the base address
    typedef enum logic [1:0] {
        STATUS  = 2'd0,   // Flags, write 1 clears errors
        TX_DATA = 2'd1,   // Write launches a byte
        RX_DATA = 2'd2,   // Read frees the holding register
        CONTROL = 2'd3    // Interrupt enable
    } reg_offset_t;

    // Bit positions inside STATUS
    typedef enum logic [2:0] {
        TX_READY  = 3'd0,
        RX_VALID  = 3'd1,
        OVERRUN   = 3'd2,
        FRAME_ERR = 3'd3
    } status_bit_e;

    // Receive interrupt enable within CONTROL
    localparam int CTRL_RX_IE = 0;

endpackage

//--- verilog/uart_line_pkg.sv
// ==========================================================================
// Serial line types shared by the transmit and receive sequencers.
// Frame is fixed at 8 data bits, no parity, one stop bit
// ==========================================================================
package uart_line_pkg;

    localparam int DATA_BITS = 8;

    // Bit currently on the tx line
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Bit the receiver expects next
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

//--- verilog/uart_byte_if.sv
// ==========================================================================
// One byte plus credit handshake between the register block and an engine.
// Only the sending side of a link drives data and push
// ==========================================================================
`timescale 1ns/1ns

interface uart_byte_if;

    logic [7:0] data;
    logic       push;        // One cycle, data valid
    logic       credit;      // Level, the sender may push
    logic       done;        // One cycle, credit return or frame end
    logic       frame_err;   // One cycle, bad stop bit

    // Engine sends on the receive link and returns done on the transmit link
    modport engine (output data, push, done, frame_err, input credit);

    // Register block sends on the transmit link and grants credit on both
    modport regs (output data, push, credit, input done, frame_err);

endinterface

//--- verilog/baud_tick_gen.sv
// ==========================================================================
// Oversample tick, one cycle wide every UART_TICK_DIV clocks.
// Counting starts at reset release, so tick phase follows reset
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module baud_tick_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int DIV = `UART_TICK_DIV;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] count;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == CW'(DIV - 1))
        begin
            count <= '0;   // Wrap
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    // With a real divider the engines rely on isolated ticks
    if (DIV > 1)
    begin : g_tick_check
        a_single_tick: assert property (@(posedge clk) disable iff (!reset)
            tick |=> !tick);
    end

endmodule

//--- verilog/uart_tx_fsm.sv
// ==========================================================================
// Transmit sequencer. Start bit waits for the next bit boundary, so the
// line may stay idle up to one bit after push. Frame is 10 bits, LSB first
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_tx_fsm (
    input  logic      clk,
    input  logic      reset,
    input  logic      tick,
    uart_byte_if.engine link,
    output logic      tx
);

    localparam int OS = `UART_OVERSAMPLE;
    localparam int PW = $clog2(OS);

    uart_line_pkg::tx_state_t state;
    logic [PW-1:0] phase;      // Free-running position within a bit
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          loaded;     // Byte waiting for the next boundary
    logic          boundary;

    assign boundary = tick && (phase == PW'(OS - 1));

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= uart_line_pkg::TX_IDLE;
            phase     <= '0;
            bit_idx   <= '0;
            loaded    <= 1'b0;
            tx        <= 1'b1;
            link.done <= 1'b0;
        end
        else
        begin
            link.done <= 1'b0;
            if (tick)
                phase <= phase + 1'b1;
            if (link.push)
                loaded <= 1'b1;
            if (boundary)
            begin
                case (state)
                    uart_line_pkg::TX_IDLE:
                        if (loaded)
                        begin
                            tx     <= 1'b0;   // Start bit
                            loaded <= 1'b0;
                            state  <= uart_line_pkg::TX_START;
                        end
                    uart_line_pkg::TX_START:
                    begin
                        tx      <= shift[0];
                        bit_idx <= '0;
                        state   <= uart_line_pkg::TX_DATA;
                    end
                    uart_line_pkg::TX_DATA:
                        if (bit_idx == 3'(uart_line_pkg::DATA_BITS - 1))
                        begin
                            tx    <= 1'b1;    // Stop bit
                            state <= uart_line_pkg::TX_STOP;
                        end
                        else
                        begin
                            tx      <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    default:
                    begin
                        link.done <= 1'b1;    // Stop bit over, credit back
                        state     <= uart_line_pkg::TX_IDLE;
                    end
                endcase
            end
        end
    end

    // Payload shifts out one bit per data boundary
    always_ff @(posedge clk)
    begin
        if (link.push)
            shift <= link.data;
        else if (boundary && (state != uart_line_pkg::TX_IDLE))
            shift <= shift >> 1;
    end

    // A push outside idle means the register block broke the credit rule
    // Credit is taken in the same edge that raises push, so it is seen one cycle back
    a_push_idle: assert property (@(posedge clk) disable iff (!reset)
        link.push |-> (state == uart_line_pkg::TX_IDLE) && !loaded && $past(link.credit));

endmodule

//--- verilog/uart_rx_fsm.sv
// ==========================================================================
// Receive sequencer. Start bit is confirmed at mid-bit, data and stop bit
// are sampled once each. It never stalls, a byte without credit is dropped
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_rx_fsm (
    input  logic      clk,
    input  logic      reset,
    input  logic      tick,
    input  logic      rx,
    uart_byte_if.engine link
);

    localparam int OS = `UART_OVERSAMPLE;
    localparam int PW = $clog2(OS);

    uart_line_pkg::rx_state_t state;
    logic          rx_meta;
    logic          rx_s;       // Synchronised line
    logic [PW-1:0] cnt;        // Ticks since the last sample
    logic [2:0]    bit_idx;
    logic [7:0]    shift;
    logic          sample;

    // Start check lands half a bit in, the rest one bit apart
    assign sample = tick && ((state == uart_line_pkg::RX_START)
                             ? (cnt == PW'(OS / 2 - 1))
                             : (cnt == PW'(OS - 1)));

    assign link.data = shift;  // Stable until the next frame's data bits

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_meta        <= 1'b1;
            rx_s           <= 1'b1;
            state          <= uart_line_pkg::RX_IDLE;
            cnt            <= '0;
            bit_idx        <= '0;
            link.push      <= 1'b0;
            link.done      <= 1'b0;
            link.frame_err <= 1'b0;
        end
        else
        begin
            rx_meta        <= rx;
            rx_s           <= rx_meta;
            link.push      <= 1'b0;
            link.done      <= 1'b0;
            link.frame_err <= 1'b0;
            if (tick)
                cnt <= sample ? '0 : cnt + 1'b1;
            case (state)
                uart_line_pkg::RX_IDLE:
                    if (tick && !rx_s)
                    begin
                        cnt   <= '0;
                        state <= uart_line_pkg::RX_START;
                    end
                uart_line_pkg::RX_START:
                    if (sample)
                    begin
                        bit_idx <= '0;
                        state   <= rx_s ? uart_line_pkg::RX_IDLE   // Glitch
                                        : uart_line_pkg::RX_DATA;
                    end
                uart_line_pkg::RX_DATA:
                    if (sample)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'(uart_line_pkg::DATA_BITS - 1))
                            state <= uart_line_pkg::RX_STOP;
                    end
                default:
                    if (sample)
                    begin
                        link.push      <= rx_s && link.credit;
                        link.done      <= rx_s;       // Good frame, pushed or not
                        link.frame_err <= !rx_s;
                        state          <= uart_line_pkg::RX_IDLE;
                    end
            endcase
        end
    end

    // Data bits enter at the top, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (sample && (state == uart_line_pkg::RX_DATA))
            shift <= {rx_s, shift[7:1]};
    end

    a_push_xor_err: assert property (@(posedge clk) disable iff (!reset)
        !(link.push && link.frame_err));

endmodule

//--- verilog/uart_regs.sv
// ==========================================================================
// Bus registers of the UART. Reads are combinational and return zero off
// the window. Writes to TX_DATA without TX_READY are dropped
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    write_en,
    input  logic [`UART_ADDR_W-1:0] addr,
    input  logic [7:0]              data_in,
    output logic [7:0]              data_out,
    output logic                    interrupt,
    uart_byte_if.regs               tx_link,
    uart_byte_if.regs               rx_link
);

    logic [`UART_ADDR_W-1:0]  rel_addr;
    logic                     sel;
    uart_reg_pkg::reg_offset_t offset;
    logic                     wr_status;
    logic                     wr_tx;
    logic                     rd_rx;
    logic                     tx_credit;
    logic                     rx_valid;
    logic [7:0]               rx_hold;
    logic                     overrun;
    logic                     frame_err;
    logic                     rx_ie;
    logic [7:0]               status;

    // Below the base the difference wraps high and falls outside
    assign rel_addr  = addr - `UART_BASE_ADDR;
    assign sel       = enable && (rel_addr < `UART_ADDR_W'(4));
    assign offset    = uart_reg_pkg::reg_offset_t'(rel_addr[1:0]);
    assign wr_status = sel && write_en && (offset == uart_reg_pkg::STATUS);
    assign wr_tx     = sel && write_en && (offset == uart_reg_pkg::TX_DATA) && tx_credit;
    assign rd_rx     = sel && !write_en && (offset == uart_reg_pkg::RX_DATA);

    assign tx_link.credit = tx_credit;
    assign rx_link.credit = !rx_valid;   // One-deep holding register

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_credit      <= 1'b1;
            tx_link.push   <= 1'b0;
            rx_valid       <= 1'b0;
            overrun        <= 1'b0;
            frame_err      <= 1'b0;
            rx_ie          <= 1'b0;
            interrupt      <= 1'b0;
        end
        else
        begin
            tx_link.push <= wr_tx;
            if (wr_tx)
                tx_credit <= 1'b0;
            else if (tx_link.done)
                tx_credit <= 1'b1;

            if (rx_link.push)
                rx_valid <= 1'b1;
            else if (rd_rx)
                rx_valid <= 1'b0;
            interrupt <= rx_link.push && rx_ie;

            // Sticky errors, a new event wins over the clear
            if (rx_link.done && !rx_link.push)
                overrun <= 1'b1;
            else if (wr_status && data_in[uart_reg_pkg::OVERRUN])
                overrun <= 1'b0;
            if (rx_link.frame_err)
                frame_err <= 1'b1;
            else if (wr_status && data_in[uart_reg_pkg::FRAME_ERR])
                frame_err <= 1'b0;

            if (sel && write_en && (offset == uart_reg_pkg::CONTROL))
                rx_ie <= data_in[uart_reg_pkg::CTRL_RX_IE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_tx)
            tx_link.data <= data_in;
        if (rx_link.push)
            rx_hold <= rx_link.data;
    end

    always_comb
    begin
        status = '0;
        status[uart_reg_pkg::TX_READY]  = tx_credit;
        status[uart_reg_pkg::RX_VALID]  = rx_valid;
        status[uart_reg_pkg::OVERRUN]   = overrun;
        status[uart_reg_pkg::FRAME_ERR] = frame_err;
    end

    always_comb
    begin
        data_out = '0;
        if (sel)
        begin
            case (offset)
                uart_reg_pkg::STATUS:  data_out = status;
                uart_reg_pkg::RX_DATA: data_out = rx_hold;
                uart_reg_pkg::CONTROL: data_out[uart_reg_pkg::CTRL_RX_IE] = rx_ie;
                default:               data_out = '0;   // TX_DATA is write only
            endcase
        end
    end

    // Window by plain compare, independent of the wrapped offset
    a_quiet_bus: assert property (@(posedge clk) disable iff (!reset)
        (!enable || (32'(addr) < 32'(`UART_BASE_ADDR))
                 || (32'(addr) >= 32'(`UART_BASE_ADDR) + 32'd4)) |-> (data_out == 8'h00));

endmodule

//--- verilog/uart_top.sv
// ==========================================================================
// UART peripheral top, four byte registers at UART_BASE_ADDR.
// 8N1 only, no FIFO, receive interrupt is a single-cycle pulse
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    write_en,
    input  logic [`UART_ADDR_W-1:0] addr,
    input  logic [7:0]              data_in,
    output logic [7:0]              data_out,
    output logic                    interrupt,
    input  logic                    rx,
    output logic                    tx
);

    logic tick;

    uart_byte_if tx_link ();
    uart_byte_if rx_link ();

    baud_tick_gen tick_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_tx_fsm tx_engine (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .link  (tx_link.engine),
        .tx    (tx)
    );

    uart_rx_fsm rx_engine (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .rx    (rx),
        .link  (rx_link.engine)
    );

    uart_regs regs (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .write_en  (write_en),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .interrupt (interrupt),
        .tx_link   (tx_link.regs),
        .rx_link   (rx_link.regs)
    );

endmodule

//--- bench/tb_uart_line.sv
// ==========================================================================
// Serial line model at the default bit time, 8N1 only.
// The monitor assumes tx idles high between frames
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module tb_uart_line (
    input  logic clk,
    input  logic tx,
    output logic rx
);

    localparam int BIT_CYCLES = `UART_TICK_DIV * `UART_OVERSAMPLE;

    logic [7:0] tx_bytes[$];   // Decoded from tx, oldest first
    logic [7:0] mon_shift;
    int         mon_bit;
    int         bad_frames;    // Wrong start or stop bit seen on tx

    initial
    begin
        rx         = 1'b1;
        bad_frames = 0;
    end

    // Sends one frame on rx, edges 2 ns after the clock
    task automatic send_frame(input logic [7:0] value, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, value, 1'b0};
        @(posedge clk);
        #2;
        for (i = 0; i < 10; i++)
        begin
            rx = bits[i];
            repeat (BIT_CYCLES) @(posedge clk);
            #2;
        end
        rx = 1'b1;   // Back to idle, matters after a bad stop bit
    endtask

    // Hands out the oldest decoded byte, found is 0 when none is waiting
    task automatic take_byte(output logic [7:0] value, output bit found);
        found = (tx_bytes.size() > 0);
        value = 8'h00;
        if (found)
            value = tx_bytes.pop_front();
    endtask

    // Frame monitor, samples every bit in its middle
    always
    begin
        @(negedge tx);
        repeat (BIT_CYCLES / 2) @(posedge clk);
        if (tx !== 1'b0)
            bad_frames++;   // Start bit gone at mid-bit
        else
        begin
            for (mon_bit = 0; mon_bit < 8; mon_bit++)
            begin
                repeat (BIT_CYCLES) @(posedge clk);
                mon_shift[mon_bit] = tx;
            end
            repeat (BIT_CYCLES) @(posedge clk);
            if (tx !== 1'b1)
                bad_frames++;
            tx_bytes.push_back(mon_shift);
        end
    end

endmodule

//--- bench/tb_uart.sv
// ==========================================================================
// Testbench of the UART peripheral with the defaults of the config header.
// Stops at the first error, random bytes come from a fixed seed
// ==========================================================================
`timescale 1ns/1ns
`include "uart_config.svh"

module tb_uart;

    localparam int BIT_CYCLES   = `UART_TICK_DIV * `UART_OVERSAMPLE;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int CYCLE_LIMIT  = 125 * FRAME_CYCLES;   // About 40 frames with margin
    localparam int NUM_BYTES    = 12;

    logic                    clk;
    logic                    reset;
    logic                    enable;
    logic                    write_en;
    logic [`UART_ADDR_W-1:0] addr;
    logic [7:0]              data_in;
    logic [7:0]              data_out;
    logic                    interrupt;
    logic                    rx;
    logic                    tx;

    integer     seed = 32'hf36a_98ab;
    int         cycles = 0;
    int         irq_count = 0;

    // Reference model
    logic       exp_rx_valid;
    logic       exp_overrun;
    logic       exp_frame_err;
    logic [7:0] exp_hold;
    int         exp_irq;
    logic [7:0] exp_tx[$];

    uart_top DUT (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .write_en  (write_en),
        .addr      (addr),
        .data_in   (data_in),
        .data_out  (data_out),
        .interrupt (interrupt),
        .rx        (rx),
        .tx        (tx)
    );

    tb_uart_line line (
        .clk (clk),
        .tx  (tx),
        .rx  (rx)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        if (reset === 1'b1 && interrupt === 1'b1)
            irq_count++;   // One count per high cycle
        cycles++;
        if (cycles >= CYCLE_LIMIT)
            report_failure("run did not finish within the cycle limit");
    end

    function automatic logic [`UART_ADDR_W-1:0] reg_addr(input uart_reg_pkg::reg_offset_t off);
        return `UART_ADDR_W'(`UART_BASE_ADDR) + `UART_ADDR_W'(off);
    endfunction

    function automatic logic [7:0] random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Only read with the transmitter idle, so TX_READY is expected high
    function automatic logic [7:0] expected_status();
        logic [7:0] s;
        s = 8'h00;
        s[uart_reg_pkg::TX_READY]  = 1'b1;
        s[uart_reg_pkg::RX_VALID]  = exp_rx_valid;
        s[uart_reg_pkg::OVERRUN]   = exp_overrun;
        s[uart_reg_pkg::FRAME_ERR] = exp_frame_err;
        return s;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    // Bus tasks start and end 2 ns after a rising edge
    task automatic write_bus(input logic [`UART_ADDR_W-1:0] a, input logic [7:0] d);
        addr     = a;
        data_in  = d;
        enable   = 1'b1;
        write_en = 1'b1;
        @(posedge clk);
        #2;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic read_bus(input logic [`UART_ADDR_W-1:0] a, output logic [7:0] d);
        addr     = a;
        enable   = 1'b1;
        write_en = 1'b0;
        @(negedge clk);
        d = data_out;      // Mid-cycle, read mux settled
        @(posedge clk);
        #2;
        enable = 1'b0;
    endtask

    task automatic check_status();
        logic [7:0] got;
        read_bus(reg_addr(uart_reg_pkg::STATUS), got);
        check_value("STATUS", got, expected_status());
    endtask

    // Polls one STATUS bit until it takes the given value
    task automatic wait_flag(input int pos, input logic value);
        logic [7:0] s;
        int         polls;
        polls = 0;
        read_bus(reg_addr(uart_reg_pkg::STATUS), s);
        while (s[pos] !== value && polls < 2 * FRAME_CYCLES)
        begin
            polls++;
            read_bus(reg_addr(uart_reg_pkg::STATUS), s);
        end
        assert (s[pos] === value)
        else
            report_failure($sformatf("STATUS bit %0d never became %0b", pos, value));
    endtask

    task automatic check_tx_byte();
        logic [7:0] got;
        bit         found;
        line.take_byte(got, found);
        assert (found)
        else
            report_failure("no frame decoded on tx before TX_READY returned");
        check_value("tx byte", got, exp_tx.pop_front());
    endtask

    // One good frame on rx, then the read of RX_DATA
    task automatic receive_byte(input logic [7:0] b, input logic irq_on);
        logic [7:0] got;
        line.send_frame(b, 1'b1);
        wait_flag(uart_reg_pkg::RX_VALID, 1'b1);
        exp_rx_valid = 1'b1;
        exp_hold     = b;
        if (irq_on)
            exp_irq++;
        check_value("interrupt count", 8'(irq_count), 8'(exp_irq));
        check_status();
        read_bus(reg_addr(uart_reg_pkg::RX_DATA), got);
        check_value("RX_DATA", got, exp_hold);
        exp_rx_valid = 1'b0;
        check_status();
    endtask

    initial
    begin : main
        logic [7:0] got;
        logic [7:0] b;
        bit         found;
        clk      = 1'b0;
        reset    = 1'b0;
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = 8'h00;
        exp_rx_valid  = 1'b0;
        exp_overrun   = 1'b0;
        exp_frame_err = 1'b0;
        exp_hold      = 8'h00;
        exp_irq       = 0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b1;
        idle(2);

        // Idle state and the address window
        check_value("tx", 8'(tx), 8'h01);
        check_value("interrupt", 8'(interrupt), 8'h00);
        check_status();
        read_bus(`UART_ADDR_W'(`UART_BASE_ADDR + 4), got);
        check_value("data_out above window", got, 8'h00);
        read_bus(`UART_ADDR_W'(`UART_BASE_ADDR - 1), got);
        check_value("data_out below window", got, 8'h00);

        // Transmit, one byte in flight at a time
        repeat (NUM_BYTES)
        begin
            b = random_byte();
            wait_flag(uart_reg_pkg::TX_READY, 1'b1);
            write_bus(reg_addr(uart_reg_pkg::TX_DATA), b);
            exp_tx.push_back(b);
            read_bus(reg_addr(uart_reg_pkg::STATUS), got);
            check_value("TX_READY after write", 8'(got[uart_reg_pkg::TX_READY]), 8'h00);
            wait_flag(uart_reg_pkg::TX_READY, 1'b1);
            check_tx_byte();
        end

        // Second write without credit is lost
        b = random_byte();
        write_bus(reg_addr(uart_reg_pkg::TX_DATA), b);
        exp_tx.push_back(b);
        write_bus(reg_addr(uart_reg_pkg::TX_DATA), random_byte());
        wait_flag(uart_reg_pkg::TX_READY, 1'b1);
        check_tx_byte();
        idle(2 * FRAME_CYCLES);
        line.take_byte(got, found);
        assert (!found)
        else
            report_failure("a TX_DATA write made without TX_READY reached tx");
        check_status();

        // Receive with and without the interrupt enable
        write_bus(reg_addr(uart_reg_pkg::CONTROL), 8'h01);
        read_bus(reg_addr(uart_reg_pkg::CONTROL), got);
        check_value("CONTROL", got, 8'h01);
        repeat (NUM_BYTES)
            receive_byte(random_byte(), 1'b1);
        write_bus(reg_addr(uart_reg_pkg::CONTROL), 8'h00);
        receive_byte(random_byte(), 1'b0);

        // Overrun, first byte kept
        b = random_byte();
        line.send_frame(b, 1'b1);
        line.send_frame(random_byte(), 1'b1);
        wait_flag(uart_reg_pkg::OVERRUN, 1'b1);
        exp_rx_valid = 1'b1;
        exp_hold     = b;
        exp_overrun  = 1'b1;
        check_status();
        check_value("interrupt count", 8'(irq_count), 8'(exp_irq));
        read_bus(reg_addr(uart_reg_pkg::RX_DATA), got);
        check_value("RX_DATA", got, exp_hold);
        exp_rx_valid = 1'b0;
        write_bus(reg_addr(uart_reg_pkg::STATUS), 8'(1 << uart_reg_pkg::OVERRUN));
        exp_overrun = 1'b0;
        check_status();

        // Bad stop bit, then a good frame
        line.send_frame(random_byte(), 1'b0);
        wait_flag(uart_reg_pkg::FRAME_ERR, 1'b1);
        exp_frame_err = 1'b1;
        check_status();
        idle(2 * BIT_CYCLES);
        receive_byte(random_byte(), 1'b0);
        write_bus(reg_addr(uart_reg_pkg::STATUS), 8'(1 << uart_reg_pkg::FRAME_ERR));
        exp_frame_err = 1'b0;
        check_status();

        check_value("bad tx frames", 8'(line.bad_frames), 8'h00);
        check_value("pending tx bytes", 8'(exp_tx.size()), 8'h00);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/uart_reg_pkg.sv
verilog/uart_line_pkg.sv
verilog/uart_byte_if.sv
verilog/baud_tick_gen.sv
verilog/uart_tx_fsm.sv
verilog/uart_rx_fsm.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/tb_uart_line.sv
bench/tb_uart.sv
